/* files.f */
+incdir+rtl
+incdir+tb
rtl/pixel_pkg.sv
rtl/cfg_pkg.sv
rtl/cmos_capture.sv
rtl/apb_cfg_regs.sv
rtl/pixel_fifo.sv
rtl/sobel_filter.sv
rtl/camera_top.sv
tb/tb_camera.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_camera
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* tb/camera_model.svh */
`ifndef CAMERA_MODEL_SVH
`define CAMERA_MODEL_SVH

rgb565_t  ref_frame [`FRAME_N]; // frame currently on the camera bus
out_pix_t expected_q[$];

function automatic int gray_at(int x, int y);
	return int'(to_gray(ref_frame[y * `FRAME_W + x]));
endfunction

// |gx| + |gy| of the 3x3 window, 0 on the border, clipped at 255
function automatic int sobel_mag(int x, int y);
	int gx;
	int gy;
	int mag;
	if (x == 0 || y == 0 || x == `FRAME_W - 1 || y == `FRAME_H - 1)
		return 0;
	gx = gray_at(x + 1, y - 1) + 2 * gray_at(x + 1, y) + gray_at(x + 1, y + 1)
		- gray_at(x - 1, y - 1) - 2 * gray_at(x - 1, y) - gray_at(x - 1, y + 1);
	gy = gray_at(x - 1, y + 1) + 2 * gray_at(x, y + 1) + gray_at(x + 1, y + 1)
		- gray_at(x - 1, y - 1) - 2 * gray_at(x, y - 1) - gray_at(x + 1, y - 1);
	mag = (gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy);
	return (mag > 255) ? 255 : mag;
endfunction

// queue one result per pixel in raster order
task automatic model_expect(input mode_t m, input thresh_t t);
	out_pix_t e;
	gray_t    g;
	for (int y = 0; y < `FRAME_H; y++) begin
		for (int x = 0; x < `FRAME_W; x++) begin
			g     = to_gray(ref_frame[y * `FRAME_W + x]);
			e.sof = (x == 0) && (y == 0);
			e.eol = (x == `FRAME_W - 1);
			case (m)
				MODE_SOBEL: e.pix = (sobel_mag(x, y) > int'(t)) ? 16'hffff : 16'h0000;
				MODE_GRAY: begin // top bits per channel
					e.pix.r = 5'(g >> 3);
					e.pix.g = 6'(g >> 2);
					e.pix.b = 5'(g >> 3);
				end
				default:    e.pix = ref_frame[y * `FRAME_W + x];
			endcase
			expected_q.push_back(e);
		end
	end
endtask

`endif

/* tb/tb_camera.sv */
`timescale 1ns/1ps
`default_nettype none

`include "camera_defs.svh"

module tb_camera;
	import pixel_pkg::*;
	import cfg_pkg::*;

	localparam int NUM_FRAMES     = 8;
	localparam int TIMEOUT_CYCLES = 4 * NUM_FRAMES * (`FRAME_N * 3) + 2000;

	logic        pi_clk;
	logic        rst;
	logic        cam_vs;
	logic        cam_hs;
	logic [7:0]  cam_data;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [3:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        out_valid;
	logic        out_ready    = 1'b0;
	out_pix_t    out_pix;
	logic        backpressure = 1'b0;
	string       test_name    = "reset";
	out_pix_t    mon_exp;
	int          cycle_count  = 0;
	int          pix_errors   = 0;
	int          reg_errors   = 0;
	int          flag_errors  = 0;
	int          other_errors = 0;

	`include "camera_model.svh"

	camera_top dut_i (.*);

	initial begin
		pi_clk = 1'b0;
		forever #2 pi_clk = ~pi_clk;
	end

	task automatic check_pix(input string name, input out_pix_t exp, input out_pix_t act);
		if (exp !== act) begin
			pix_errors++;
			$display("[FAIL] %s: expected sof=%0b eol=%0b pix=%04h, actual sof=%0b eol=%0b pix=%04h",
				name, exp.sof, exp.eol, exp.pix, act.sof, act.eol, act.pix);
		end
	endtask

	task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			reg_errors++;
			$display("[FAIL] %s: expected %08h, actual %08h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			flag_errors++;
			$display("[FAIL] %s: expected %0b, actual %0b", name, exp, act);
		end
	endtask

	// setup phase then access phase, response held until the falling edge after it completes
	task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		@(negedge pi_clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge pi_clk);
		penable = 1'b1;
		@(negedge pi_clk); // zero wait states, done on the rising edge before
		check_flag("pready in access phase", 1'b1, pready);
		rdata   = prdata;
		err     = pslverr;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic random_frame();
		for (int i = 0; i < `FRAME_N; i++)
			ref_frame[i] = 16'($urandom);
	endtask

	// vs pulse, then lines of high/low byte pairs with idle gaps
	task automatic send_frame();
		@(negedge pi_clk);
		cam_vs = 1'b1;
		@(negedge pi_clk);
		cam_vs = 1'b0;
		for (int y = 0; y < `FRAME_H; y++) begin
			repeat (1 + $urandom % 4) @(negedge pi_clk);
			for (int x = 0; x < `FRAME_W; x++) begin
				cam_hs   = 1'b1;
				cam_data = ref_frame[y * `FRAME_W + x][15:8];
				@(negedge pi_clk);
				cam_data = ref_frame[y * `FRAME_W + x][7:0];
				@(negedge pi_clk);
			end
			cam_hs = 1'b0;
		end
	endtask

	task automatic wait_drain();
		while (expected_q.size() != 0)
			@(posedge pi_clk);
	endtask

	task automatic run_frame(input string name, input mode_t m, input thresh_t t, input logic bp);
		logic [31:0] rd;
		logic        err;
		test_name    = name;
		backpressure = bp;
		apb_access(1'b1, ADDR_MODE, 32'(m), rd, err);
		apb_access(1'b1, ADDR_THRESH, 32'(t), rd, err);
		check_flag({name, " config pslverr"}, 1'b0, err);
		random_frame();
		model_expect(m, t);
		send_frame();
		wait_drain();
	endtask

	// handshake is stable here and completes on the next rising edge
	always @(negedge pi_clk) begin
		out_ready = backpressure ? (($urandom % 100) >= 30) : 1'b1; // low about 30%
		if (!rst && out_valid && out_ready) begin
			if (expected_q.size() == 0) begin
				other_errors++;
				$display("unexpected output pixel %04h during %s", out_pix.pix, test_name);
			end else begin
				mon_exp = expected_q.pop_front();
				check_pix(test_name, mon_exp, out_pix);
			end
		end
	end

	initial begin
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge pi_clk);
			cycle_count++;
		end
		$display("timeout after %0d cycles, the test sequence did not finish", cycle_count);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		logic [31:0] rd;
		logic        err;
		void'($urandom(32'hdcce6383));
		rst      = 1'b1;
		cam_vs   = 1'b0;
		cam_hs   = 1'b0;
		cam_data = 8'h00;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = 4'h0;
		pwdata   = 32'd0;
		repeat (16) @(posedge pi_clk);
		@(negedge pi_clk);
		rst = 1'b0;

		check_flag("reset out_valid", 1'b0, out_valid);
		check_flag("reset pslverr", 1'b0, pslverr);
		apb_access(1'b0, ADDR_MODE, 32'd0, rd, err);
		check_reg("reset mode", 32'h0, rd);
		apb_access(1'b0, ADDR_THRESH, 32'd0, rd, err);
		check_reg("reset thresh", 32'h40, rd);
		apb_access(1'b0, ADDR_DROPS, 32'd0, rd, err);
		check_reg("reset drops", 32'h0, rd);

		test_name = "registers";
		apb_access(1'b1, ADDR_THRESH, 32'h0000_00a5, rd, err);
		check_flag("thresh write pslverr", 1'b0, err);
		apb_access(1'b0, ADDR_THRESH, 32'd0, rd, err);
		check_reg("thresh readback", 32'ha5, rd);
		apb_access(1'b1, ADDR_MODE, 32'd2, rd, err);
		apb_access(1'b0, ADDR_MODE, 32'd0, rd, err);
		check_reg("mode readback", 32'd2, rd);
		apb_access(1'b0, 4'hc, 32'd0, rd, err);
		check_flag("unknown read pslverr", 1'b1, err);
		apb_access(1'b1, 4'h2, 32'h1, rd, err);
		check_flag("unknown write pslverr", 1'b1, err);

		run_frame("pass", MODE_PASS, 8'h40, 1'b0);
		run_frame("gray", MODE_GRAY, 8'h40, 1'b1);
		run_frame("sobel 0x20", MODE_SOBEL, 8'h20, 1'b1);
		run_frame("sobel 0xc0", MODE_SOBEL, 8'hc0, 1'b1);
		run_frame("pass backpressure", MODE_PASS, 8'h40, 1'b1);

		// second frame lands while the first one is scanned out
		test_name    = "drops";
		backpressure = 1'b0;
		apb_access(1'b1, ADDR_MODE, 32'(MODE_PASS), rd, err);
		apb_access(1'b0, ADDR_DROPS, 32'd0, rd, err);
		check_reg("drops before overrun", 32'h0, rd);
		random_frame();
		model_expect(MODE_PASS, 8'h40);
		send_frame();
		random_frame();
		send_frame();
		wait_drain();
		repeat (200) @(negedge pi_clk); // watch for a partial frame
		check_flag("out_valid after partial frame", 1'b0, out_valid);
		apb_access(1'b0, ADDR_DROPS, 32'd0, rd, err);
		if (rd == 32'd0) begin
			other_errors++;
			$display("drop counter is still zero after the camera overran the input FIFO");
		end

		run_frame("resync after drops", MODE_SOBEL, 8'h60, 1'b1);

		$display("summary: %0d pixel errors, %0d register errors, %0d flag errors, %0d other errors",
			pix_errors, reg_errors, flag_errors, other_errors);
		if (pix_errors + reg_errors + flag_errors + other_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/camera_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "camera_defs.svh"

module camera_top (
	input  wire logic           pi_clk,
	input  wire logic           rst,
	input  wire logic           cam_vs,
	input  wire logic           cam_hs,
	input  wire logic [7:0]     cam_data,
	input  wire logic           psel,
	input  wire logic           penable,
	input  wire logic           pwrite,
	input  wire logic [3:0]     paddr,
	input  wire logic [31:0]    pwdata,
	output logic [31:0]         prdata,
	output logic                pready,
	output logic                pslverr,
	output logic                out_valid,
	input  wire logic           out_ready,
	output pixel_pkg::out_pix_t out_pix
);
	import pixel_pkg::*;
	import cfg_pkg::*;

	logic               in_push;
	cam_pix_t           in_push_data;
	logic               in_full;
	logic               in_empty;
	logic               in_pop;
	cam_pix_t           in_pop_data;
	logic               out_push;
	out_pix_t           out_push_data;
	logic               out_full;
	logic               out_empty;
	logic [`DROP_W-1:0] drops;
	mode_t              mode;
	thresh_t            thresh;

	assign out_valid = ~out_empty;

	cmos_capture capture_i (
		.pi_clk    (pi_clk),
		.rst       (rst),
		.cam_vs    (cam_vs),
		.cam_hs    (cam_hs),
		.cam_data  (cam_data),
		.fifo_full (in_full),
		.push      (in_push),
		.push_data (in_push_data),
		.drops     (drops)
	);

	pixel_fifo #(.payload_t(cam_pix_t), .DEPTH(`IN_FIFO_DEPTH)) in_fifo_i (
		.pi_clk    (pi_clk),
		.rst       (rst),
		.push      (in_push),
		.push_data (in_push_data),
		.pop       (in_pop),
		.pop_data  (in_pop_data),
		.empty     (in_empty),
		.full      (in_full)
	);

	sobel_filter filter_i (
		.pi_clk   (pi_clk),
		.rst      (rst),
		.in_empty (in_empty),
		.in_data  (in_pop_data),
		.out_full (out_full),
		.mode     (mode),
		.thresh   (thresh),
		.in_pop   (in_pop),
		.out_push (out_push),
		.out_data (out_push_data)
	);

	// drained by the display side
	pixel_fifo #(.payload_t(out_pix_t), .DEPTH(`OUT_FIFO_DEPTH)) out_fifo_i (
		.pi_clk    (pi_clk),
		.rst       (rst),
		.push      (out_push),
		.push_data (out_push_data),
		.pop       (out_valid & out_ready),
		.pop_data  (out_pix),
		.empty     (out_empty),
		.full      (out_full)
	);

	apb_cfg_regs cfg_i (
		.pi_clk  (pi_clk),
		.rst     (rst),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.drops   (drops),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.mode    (mode),
		.thresh  (thresh)
	);

endmodule

`default_nettype wire

/* rtl/sobel_filter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "camera_defs.svh"

module sobel_filter (
	input  wire logic          pi_clk,
	input  wire logic          rst,
	input  wire logic          in_empty,
	input  pixel_pkg::cam_pix_t in_data,
	input  wire logic          out_full,
	input  cfg_pkg::mode_t     mode,
	input  cfg_pkg::thresh_t   thresh,
	output logic               in_pop,
	output logic               out_push,
	output pixel_pkg::out_pix_t out_data
);
	import pixel_pkg::*;
	import cfg_pkg::*;

	localparam int AW = `ADDR_W;
	localparam int XW = `X_W;
	localparam int YW = `Y_W;

	typedef enum logic {LOAD, SCAN} state_t;

	state_t        state;
	rgb565_t       pix_mem  [`FRAME_N]; // stands in for the sdram frame
	gray_t         gray_mem [`FRAME_N];
	logic [AW-1:0] waddr;
	logic [AW-1:0] wa;
	logic          frame_done;
	logic [XW-1:0] x;
	logic [YW-1:0] y;
	logic [XW-1:0] cx;
	logic [YW-1:0] ry;
	mode_t         mode_q;
	thresh_t       thresh_q;
	gray_t         win [3][3];
	logic [9:0]    gx_pos, gx_neg, gy_pos, gy_neg;
	logic [9:0]    abs_x, abs_y;
	logic [10:0]   mag_sum;
	gray_t         mag;
	logic          border;
	gray_t         g;

	assign in_pop     = (state == LOAD) & ~in_empty;
	assign wa         = in_data.sof ? '0 : waddr; // sof restarts the frame
	assign frame_done = in_pop && (wa == AW'(`FRAME_N - 1));
	assign out_push   = (state == SCAN) & ~out_full;

	always_ff @(posedge pi_clk) begin
		if (in_pop) begin
			pix_mem[wa]  <= in_data.pix;
			gray_mem[wa] <= to_gray(in_data.pix);
		end
		if (frame_done) begin // settings hold for the whole scan
			mode_q   <= mode;
			thresh_q <= thresh;
		end
	end

	always_ff @(posedge pi_clk) begin
		if (rst) begin
			state <= LOAD;
			waddr <= '0;
			x     <= '0;
			y     <= '0;
		end else if (state == LOAD) begin
			if (frame_done) begin
				state <= SCAN;
				waddr <= '0;
			end else if (in_pop) begin
				waddr <= wa + 1'b1;
			end
		end else if (out_push) begin
			x <= x + 1'b1;
			if (x == XW'(`FRAME_W - 1)) begin
				x <= '0;
				y <= y + 1'b1;
				if (y == YW'(`FRAME_H - 1)) begin
					y     <= '0;
					state <= LOAD;
				end
			end
		end
	end

	// 3x3 gray window, wraps at the edges but borders are masked
	always_comb begin
		for (int dy = 0; dy < 3; dy++) begin
			for (int dx = 0; dx < 3; dx++) begin
				ry = y + YW'(dy) - YW'(1);
				cx = x + XW'(dx) - XW'(1);
				win[dy][dx] = gray_mem[{ry, cx}];
			end
		end
	end

	always_comb begin
		gx_pos = {2'b00, win[0][2]} + {1'b0, win[1][2], 1'b0} + {2'b00, win[2][2]};
		gx_neg = {2'b00, win[0][0]} + {1'b0, win[1][0], 1'b0} + {2'b00, win[2][0]};
		gy_pos = {2'b00, win[2][0]} + {1'b0, win[2][1], 1'b0} + {2'b00, win[2][2]};
		gy_neg = {2'b00, win[0][0]} + {1'b0, win[0][1], 1'b0} + {2'b00, win[0][2]};
		abs_x   = (gx_pos >= gx_neg) ? gx_pos - gx_neg : gx_neg - gx_pos;
		abs_y   = (gy_pos >= gy_neg) ? gy_pos - gy_neg : gy_neg - gy_pos;
		mag_sum = {1'b0, abs_x} + {1'b0, abs_y};
		border  = (x == '0) || (x == XW'(`FRAME_W - 1)) || (y == '0) ||
			(y == YW'(`FRAME_H - 1));
		if (border)
			mag = '0;
		else
			mag = (|mag_sum[10:8]) ? 8'hff : mag_sum[7:0]; // saturate
	end

	assign g = win[1][1]; // center gray

	always_comb begin
		out_data.sof = (x == '0) && (y == '0);
		out_data.eol = (x == XW'(`FRAME_W - 1));
		case (mode_q)
			MODE_SOBEL: out_data.pix = (mag > thresh_q) ? 16'hffff : 16'h0000;
			MODE_GRAY:  out_data.pix = {g[7:3], g[7:2], g[7:3]};
			default:    out_data.pix = pix_mem[{y, x}];
		endcase
	end

endmodule

`default_nettype wire

/* rtl/pixel_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_fifo #(
	parameter type payload_t = logic [15:0],
	parameter int  DEPTH     = 8
) (
	input  wire logic pi_clk,
	input  wire logic rst,
	input  wire logic push,
	input  payload_t  push_data,
	input  wire logic pop,
	output payload_t  pop_data,
	output logic      empty,
	output logic      full
);
	localparam int AW = $clog2(DEPTH);

	payload_t      mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic [AW:0]   count_nxt;
	logic          wr_en;
	logic          rd_en;

	assign wr_en     = push & ~full;
	assign rd_en     = pop & ~empty;
	assign count_nxt = count + (AW + 1)'(wr_en) - (AW + 1)'(rd_en);
	assign pop_data  = mem[rd_ptr]; // head entry, no read latency

	always_ff @(posedge pi_clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			empty  <= 1'b1;
			full   <= 1'b0;
		end else begin
			if (wr_en)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count_nxt;
			empty <= (count_nxt == '0);
			full  <= (count_nxt == (AW + 1)'(DEPTH));
		end
	end

	always_ff @(posedge pi_clk) begin
		if (wr_en)
			mem[wr_ptr] <= push_data;
	end

endmodule

`default_nettype wire

/* rtl/apb_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "camera_defs.svh"

module apb_cfg_regs (
	input  wire logic               pi_clk,
	input  wire logic               rst,
	input  wire logic               psel,
	input  wire logic               penable,
	input  wire logic               pwrite,
	input  wire logic [3:0]         paddr,
	input  wire logic [31:0]        pwdata,
	input  wire logic [`DROP_W-1:0] drops,
	output logic [31:0]             prdata,
	output logic                    pready,
	output logic                    pslverr,
	output cfg_pkg::mode_t          mode,
	output cfg_pkg::thresh_t        thresh
);
	import cfg_pkg::*;

	logic addr_ok;
	logic access;

	assign addr_ok = (paddr == ADDR_MODE) || (paddr == ADDR_THRESH) || (paddr == ADDR_DROPS);
	assign access  = psel & penable;

	assign pready  = 1'b1;             // zero wait states
	assign pslverr = access & ~addr_ok;

	always_ff @(posedge pi_clk) begin
		if (rst) begin
			mode   <= MODE_PASS;
			thresh <= THRESH_RST;
		end else if (access && pwrite) begin
			case (paddr)
				ADDR_MODE:   mode   <= mode_t'(pwdata[1:0]);
				ADDR_THRESH: thresh <= pwdata[7:0];
				default:     ; // drops is read only
			endcase
		end
	end

	always_comb begin
		case (paddr)
			ADDR_MODE:   prdata = {30'd0, mode};
			ADDR_THRESH: prdata = {24'd0, thresh};
			ADDR_DROPS:  prdata = {{(32 - `DROP_W){1'b0}}, drops};
			default:     prdata = 32'd0;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/cmos_capture.sv */
`timescale 1ns/1ps
`default_nettype none

`include "camera_defs.svh"

module cmos_capture (
	input  wire logic               pi_clk,
	input  wire logic               rst,
	input  wire logic               cam_vs,
	input  wire logic               cam_hs,
	input  wire logic [7:0]         cam_data,
	input  wire logic               fifo_full,
	output logic                    push,
	output pixel_pkg::cam_pix_t     push_data,
	output logic [`DROP_W-1:0]      drops
);
	import pixel_pkg::*;

	logic       byte_phase; // 1 while waiting for the low byte
	logic       sof_pend;   // vs seen, next pixel opens the frame
	logic [7:0] hi_byte;
	logic       low_byte;

	assign low_byte = cam_hs & byte_phase & ~cam_vs;

	always_ff @(posedge pi_clk) begin
		if (rst) begin
			byte_phase <= 1'b0;
			sof_pend   <= 1'b0;
			push       <= 1'b0;
			drops      <= '0;
		end else begin
			push <= 1'b0;
			if (cam_vs) begin
				byte_phase <= 1'b0;
				sof_pend   <= 1'b1;
			end else if (cam_hs) begin
				byte_phase <= ~byte_phase;
				if (byte_phase) begin
					if (!fifo_full) begin
						push     <= 1'b1;
						sof_pend <= 1'b0;
					end else if (drops != '1) begin
						drops <= drops + 1'b1; // saturates at all ones
					end
				end
			end
		end
	end

	always_ff @(posedge pi_clk) begin
		if (cam_hs && !byte_phase)
			hi_byte <= cam_data;
		if (low_byte) begin
			push_data.sof <= sof_pend;
			push_data.pix <= {hi_byte, cam_data};
		end
	end

endmodule

`default_nettype wire

/* rtl/cfg_pkg.sv */
`default_nettype none

package cfg_pkg;

	typedef enum logic [1:0] {
		MODE_PASS  = 2'd0,
		MODE_GRAY  = 2'd1,
		MODE_SOBEL = 2'd2
	} mode_t;

	typedef logic [7:0] thresh_t;

	// register map
	localparam logic [3:0] ADDR_MODE   = 4'h0;
	localparam logic [3:0] ADDR_THRESH = 4'h4;
	localparam logic [3:0] ADDR_DROPS  = 4'h8; // read only

	localparam thresh_t THRESH_RST = 8'h40;

endpackage

`default_nettype wire

/* rtl/pixel_pkg.sv */
`default_nettype none

package pixel_pkg;

	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} rgb565_t;

	typedef logic [7:0] gray_t;

	// input fifo payload
	typedef struct packed {
		logic    sof;
		rgb565_t pix;
	} cam_pix_t;

	// output fifo payload
	typedef struct packed {
		logic    sof;
		logic    eol;
		rgb565_t pix;
	} out_pix_t;

	// (r + 2g + b) / 4 on 8 bit channels
	function automatic gray_t to_gray(rgb565_t p);
		logic [9:0] sum;
		sum = {2'b00, p.r, 3'b000} + {1'b0, p.g, 2'b00, 1'b0} + {2'b00, p.b, 3'b000};
		return sum[9:2];
	endfunction

endpackage

`default_nettype wire

/* rtl/camera_defs.svh */
`ifndef CAMERA_DEFS_SVH
`define CAMERA_DEFS_SVH

// frame geometry, raster address is {row, col}
`define FRAME_W 16
`define FRAME_H 8
`define FRAME_N (`FRAME_W * `FRAME_H)
`define X_W 4
`define Y_W 3
`define ADDR_W (`X_W + `Y_W)

// fifo sizing
`define IN_FIFO_DEPTH 8
`define OUT_FIFO_DEPTH 4

// saturating drop counter
`define DROP_W 16

`endif
